/* bench/overlay_vectors.txt */
// columns: x y mode fire warn tens ones rgb, all hex
// mode 1 menu, 2 work, 4 off, only taken at x=1 y=1
// off after reset, requests away from frame start ignored
12c 032 1 0 0 0 0 000
230 03c 2 1 0 0 0 000
168 0c8 2 0 0 5 5 000
// menu frame
001 001 1 0 0 0 0 000
12c 032 0 0 0 0 0 fff
0f1 01f 0 0 0 0 0 fff
0f0 01f 0 0 0 0 0 000
190 06e 0 0 0 0 0 fff
191 03c 0 0 0 0 0 000
12c 01e 0 0 0 0 0 000
0bf 08d 0 0 0 0 0 fff
0be 096 0 0 0 0 0 000
1c2 0d2 0 0 0 0 0 fff
1c3 0b4 0 0 0 0 0 000
140 113 0 0 0 0 0 fff
140 137 0 0 0 0 0 000
0bf 136 0 0 0 0 0 fff
140 0f0 0 0 0 0 0 000
// work frame, fire on, tens 0, ones 7
001 001 2 1 0 0 7 000
230 03c 0 0 0 0 0 f00
209 001 0 0 0 0 0 f00
280 078 0 0 0 0 0 f00
208 03c 0 0 0 0 0 000
230 079 0 0 0 0 0 000
1c2 03c 0 0 0 0 0 000
145 0b4 0 0 0 0 0 000
168 09b 0 0 0 0 0 000
1b8 09b 0 0 0 0 0 fff
1db 0b4 0 0 0 0 0 fff
1db 0f0 0 0 0 0 0 fff
1b8 0d2 0 0 0 0 0 000
195 0b4 0 0 0 0 0 000
1b8 109 0 0 0 0 0 000
21c 09b 0 0 0 0 0 fff
1f9 0b4 0 0 0 0 0 fff
21c 109 0 0 0 0 0 fff
23f 0b4 0 0 0 0 0 000
21c 0d2 0 0 0 0 0 000
23a 09b 0 0 0 0 0 fff
258 09b 0 0 0 0 0 000
// work frame, warn on, tens 3, ones 12
001 001 2 0 1 3 c 000
230 03c 0 0 0 0 0 000
1c2 03c 0 0 0 0 0 f80
208 078 0 0 0 0 0 f80
168 09b 0 0 0 0 0 fff
145 0b4 0 0 0 0 0 000
18b 0b4 0 0 0 0 0 fff
168 0d2 0 0 0 0 0 fff
18b 0f0 0 0 0 0 0 fff
168 109 0 0 0 0 0 fff
1b8 0be 0 0 0 0 0 fff
191 097 0 0 0 0 0 fff
1e0 10e 0 0 0 0 0 fff
// changes away from frame start ignored
002 001 4 1 0 1 0 000
001 002 4 1 0 1 0 000
168 0d2 0 0 0 0 0 fff
1c2 03c 0 0 0 0 0 f80
1b8 0be 0 0 0 0 0 fff
// illegal mode keeps work, status still sampled
001 001 3 0 0 1 0 000
168 0d2 0 0 0 0 0 000
18b 0b4 0 0 0 0 0 fff
1b8 0d2 0 0 0 0 0 000
195 0b4 0 0 0 0 0 fff
1c2 03c 0 0 0 0 0 000
// off frame blanks everything
001 001 4 0 0 0 0 000
18b 0b4 0 0 0 0 0 000
12c 032 0 0 0 0 0 000
230 03c 0 0 0 0 0 000
// end marker
fff fff 0 0 0 0 0 000

/* bench/tb_status_overlay.sv */
`timescale 1ns/1ps

module tb_status_overlay
  import video_geom_pkg::*, overlay_pkg::*;
();

  localparam int PIX_DIV      = 4;
  // room for the vectors and the end marker
  localparam int MAX_VEC      = 128;
  localparam int TICK_TIMEOUT = 4 * PIX_DIV;

  logic         i_clk;
  logic         i_rst_n;
  x_coord_t     i_x;
  y_coord_t     i_y;
  screen_mode_t i_mode;
  logic         i_fire;
  logic         i_warn;
  digit_t       i_tens;
  digit_t       i_ones;
  logic [3:0]   o_red;
  logic [3:0]   o_green;
  logic [3:0]   o_blue;

  // eight words per vector at address {vector, column}
  logic [11:0]  vec_mem [0:8*MAX_VEC-1];
  int           n_vec;
  // mode the DUT should hold under the frame-start rule
  screen_mode_t exp_mode;

  status_overlay #(
    .PIX_DIV (PIX_DIV)
  ) status_overlay_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_x     (i_x),
    .i_y     (i_y),
    .i_mode  (i_mode),
    .i_fire  (i_fire),
    .i_warn  (i_warn),
    .i_tens  (i_tens),
    .i_ones  (i_ones),
    .o_red   (o_red),
    .o_green (o_green),
    .o_blue  (o_blue)
  );

  // 100 ns clock
  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_rgb(input int vec, input rgb12_t exp, input rgb12_t got);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0d ns: {o_red,o_green,o_blue} vector %0d expected %h got %h",
                          $time, vec, exp, got));
    end
  endtask

  task automatic check_mode(input screen_mode_t exp, input screen_mode_t got);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0d ns: status_overlay_inst.mode expected %b got %b",
                          $time, exp, got));
    end
  endtask

  // only the three one-hot codes are accepted
  function automatic logic mode_is_legal(input logic [2:0] code);
    return (code == MODE_OFF) || (code == MODE_MENU) || (code == MODE_WORK);
  endfunction

  // returns 1 ns into a clock whose closing edge carries the strobe
  task automatic wait_tick_cycle();
    int n;
    n = 0;
    @(posedge i_clk);
    #1;
    while (status_overlay_inst.pix_tick !== 1'b1) begin
      n++;
      if (n > TICK_TIMEOUT) begin
        abort_run($sformatf("pixel strobe did not come within %0d clocks", TICK_TIMEOUT));
      end
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic drive_vector(input logic [6:0] vidx);
    logic [2:0] code;
    code   = vec_mem[{vidx, 3'd2}][2:0];
    i_x    = vec_mem[{vidx, 3'd0}][10:0];
    i_y    = vec_mem[{vidx, 3'd1}][9:0];
    i_mode = screen_mode_t'(code);
    i_fire = vec_mem[{vidx, 3'd3}][0];
    i_warn = vec_mem[{vidx, 3'd4}][0];
    i_tens = vec_mem[{vidx, 3'd5}][3:0];
    i_ones = vec_mem[{vidx, 3'd6}][3:0];
    // new mode is visible from the next strobe on
    if ((i_x == FRAME_X0) && (i_y == FRAME_Y0) && mode_is_legal(code)) begin
      exp_mode = screen_mode_t'(code);
    end
  endtask

  initial begin
    int         k;
    logic [6:0] vidx;
    i_rst_n  = 1'b0;
    i_x      = '0;
    i_y      = '0;
    i_mode   = MODE_OFF;
    i_fire   = 1'b0;
    i_warn   = 1'b0;
    i_tens   = '0;
    i_ones   = '0;
    exp_mode = MODE_OFF;
    n_vec    = 0;
    $readmemh("bench/overlay_vectors.txt", vec_mem);
    if ($isunknown(vec_mem[0])) begin
      abort_run("vector file could not be read");
    end
    // count up to the end marker
    vidx = '0;
    while (vec_mem[{vidx, 3'd0}] !== 12'hfff) begin
      if (n_vec == MAX_VEC - 1) begin
        abort_run("vector file has no end marker");
      end
      n_vec++;
      vidx = 7'(n_vec);
    end

    // reset held for 4 clocks
    repeat (4) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    // two pixels in flight so vector k-2 is on the outputs now
    for (k = 0; k < n_vec + 2; k++) begin
      wait_tick_cycle();
      check_mode(exp_mode, status_overlay_inst.mode);
      if (k >= 2) begin
        vidx = 7'(k - 2);
        check_rgb(k - 2, rgb12_t'(vec_mem[{vidx, 3'd7}]),
                  rgb12_t'({o_red, o_green, o_blue}));
      end
      // last vector stays on the inputs while the pipe drains
      if (k < n_vec) begin
        drive_vector(7'(k));
      end
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* files.f */
verilog/video_geom_pkg.sv
verilog/overlay_pkg.sv
verilog/pixel_tick_gen.sv
verilog/seg_glyph.sv
verilog/screen_mode_fsm.sv
verilog/region_decoder.sv
verilog/pixel_shader.sv
verilog/status_overlay.sv
bench/tb_status_overlay.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" \
  && verilator --binary --assert --top-module tb_status_overlay -f files.f \
  && ./obj_dir/Vtb_status_overlay | tee /dev/stderr | grep -q "NO ERRORS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verilog/overlay_pkg.sv */
package overlay_pkg;

  // one-hot screen modes, same codes as the controller drives
  typedef enum logic [2:0] {
    MODE_MENU = 3'b001,
    MODE_WORK = 3'b010,
    MODE_OFF  = 3'b100
  } screen_mode_t;

  // what the current pixel belongs to
  typedef enum logic [3:0] {
    RG_NONE = 4'd0,
    RG_MENU = 4'd1,
    RG_FIRE = 4'd2,
    RG_WARN = 4'd3,
    RG_TENS = 4'd4,
    RG_ONES = 4'd5,
    RG_UNIT = 4'd6
  } region_t;

  // bcd temperature digit
  typedef logic [3:0] digit_t;

  // 0..9 are digits, rest are special glyphs
  typedef logic [3:0] glyph_code_t;

  localparam glyph_code_t GL_BLANK  = 4'd10;
  localparam glyph_code_t GL_UNIT_C = 4'd12;
  localparam glyph_code_t GL_FULL   = 4'd15;

  // 4:4:4 colour, red in the top nibble
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb12_t;

  localparam rgb12_t COL_BLACK = 12'h000;
  localparam rgb12_t COL_WHITE = 12'hFFF;
  localparam rgb12_t COL_FIRE  = 12'hF00;
  localparam rgb12_t COL_WARN  = 12'hF80;

endpackage

/* verilog/pixel_shader.sv */
`timescale 1ns/1ps

module pixel_shader
  import video_geom_pkg::*, overlay_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_pix_tick,
  input  region_t    i_region,
  input  cell_x_t    i_cell_x,
  input  cell_y_t    i_cell_y,
  input  digit_t     i_tens,
  input  digit_t     i_ones,
  output logic [3:0] o_red,
  output logic [3:0] o_green,
  output logic [3:0] o_blue
);

  glyph_code_t code;
  logic        lit;
  rgb12_t      rgb_d;
  rgb12_t      rgb_q;

  // out-of-range bcd shows as a solid block
  function automatic glyph_code_t digit_glyph(input digit_t d);
    return (d > 4'd9) ? GL_FULL : glyph_code_t'(d);
  endfunction

  always_comb begin
    case (i_region)
      // leading zero blanked
      RG_TENS: code = (i_tens == '0) ? GL_BLANK : digit_glyph(i_tens);
      RG_ONES: code = digit_glyph(i_ones);
      RG_UNIT: code = GL_UNIT_C;
      default: code = GL_BLANK;
    endcase
  end

  seg_glyph seg_glyph_inst (
    .i_code   (code),
    .i_cell_x (i_cell_x),
    .i_cell_y (i_cell_y),
    .o_lit    (lit)
  );

  always_comb begin
    case (i_region)
      RG_MENU:                   rgb_d = COL_WHITE;
      RG_FIRE:                   rgb_d = COL_FIRE;
      RG_WARN:                   rgb_d = COL_WARN;
      RG_TENS, RG_ONES, RG_UNIT: rgb_d = lit ? COL_WHITE : COL_BLACK;
      default:                   rgb_d = COL_BLACK;
    endcase
  end

  // second pipeline stage, colour on tick n+1
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rgb_q <= COL_BLACK;
    end else if (i_pix_tick) begin
      rgb_q <= rgb_d;
    end
  end

  assign o_red   = rgb_q.red;
  assign o_green = rgb_q.green;
  assign o_blue  = rgb_q.blue;

endmodule

/* verilog/pixel_tick_gen.sv */
`timescale 1ns/1ps

module pixel_tick_gen #(
  parameter int PIX_DIV = 4
) (
  input  logic i_clk,
  input  logic i_rst_n,
  output logic o_pix_tick
);

  localparam int CW = (PIX_DIV > 2) ? $clog2(PIX_DIV) : 1;
  // last count before wrap
  localparam logic [CW-1:0] TERM = CW'(PIX_DIV - 1);

  logic [CW-1:0] cnt_q;

  // free-running modulo counter, strobe registered off the terminal count
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      cnt_q      <= '0;
      o_pix_tick <= 1'b0;
    end else begin
      cnt_q      <= (cnt_q == TERM) ? '0 : cnt_q + 1'b1;
      o_pix_tick <= (cnt_q == TERM);
    end
  end

  // strobe is a single clock wide, never back to back
  a_tick_not_adjacent: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) o_pix_tick |=> !o_pix_tick
  ) else $error("pixel strobe high on two adjacent clocks");

endmodule

/* verilog/region_decoder.sv */
`timescale 1ns/1ps

module region_decoder
  import video_geom_pkg::*, overlay_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst_n,
  input  logic         i_pix_tick,
  input  x_coord_t     i_x,
  input  y_coord_t     i_y,
  input  screen_mode_t i_mode,
  input  logic         i_fire,
  input  logic         i_warn,
  output region_t      o_region,
  output cell_x_t      o_cell_x,
  output cell_y_t      o_cell_y
);

  region_t  region_d;
  cell_x_t  cell_x_d;
  cell_y_t  cell_y_d;
  x_coord_t unit_dx;

  // inclusive rectangle test
  function automatic logic in_box(
    input x_coord_t x,
    input y_coord_t y,
    input x_coord_t x_lo,
    input x_coord_t x_hi,
    input y_coord_t y_lo,
    input y_coord_t y_hi
  );
    return (x >= x_lo) && (x <= x_hi) && (y >= y_lo) && (y <= y_hi);
  endfunction

  // unit cell is wider than a glyph
  assign unit_dx = i_x - UNIT_CELL_X_LO;

  always_comb begin
    region_d = RG_NONE;
    cell_x_d = '0;
    cell_y_d = '0;
    case (i_mode)
      MODE_MENU: begin
        if (in_box(i_x, i_y, MENU_BOX0_X_LO, MENU_BOX0_X_HI, MENU_BOX0_Y_LO, MENU_BOX0_Y_HI) ||
            in_box(i_x, i_y, MENU_BOX1_X_LO, MENU_BOX1_X_HI, MENU_BOX1_Y_LO, MENU_BOX1_Y_HI) ||
            in_box(i_x, i_y, MENU_BOX2_X_LO, MENU_BOX2_X_HI, MENU_BOX2_Y_LO, MENU_BOX2_Y_HI)) begin
          region_d = RG_MENU;
        end
      end
      MODE_WORK: begin
        // alarm tiles first, only while their flag is set
        if (i_fire &&
            in_box(i_x, i_y, FIRE_TILE_X_LO, FIRE_TILE_X_HI, FIRE_TILE_Y_LO, FIRE_TILE_Y_HI)) begin
          region_d = RG_FIRE;
        end else if (i_warn &&
            in_box(i_x, i_y, WARN_TILE_X_LO, WARN_TILE_X_HI, WARN_TILE_Y_LO, WARN_TILE_Y_HI)) begin
          region_d = RG_WARN;
        end else if (in_box(i_x, i_y, TENS_CELL_X_LO, TENS_CELL_X_HI,
                            TENS_CELL_Y_LO, TENS_CELL_Y_HI)) begin
          region_d = RG_TENS;
          cell_x_d = cell_x_t'(i_x - TENS_CELL_X_LO);
          cell_y_d = cell_y_t'(i_y - TENS_CELL_Y_LO);
        end else if (in_box(i_x, i_y, ONES_CELL_X_LO, ONES_CELL_X_HI,
                            ONES_CELL_Y_LO, ONES_CELL_Y_HI)) begin
          region_d = RG_ONES;
          cell_x_d = cell_x_t'(i_x - ONES_CELL_X_LO);
          cell_y_d = cell_y_t'(i_y - ONES_CELL_Y_LO);
        end else if (in_box(i_x, i_y, UNIT_CELL_X_LO, UNIT_CELL_X_HI,
                            UNIT_CELL_Y_LO, UNIT_CELL_Y_HI)) begin
          region_d = RG_UNIT;
          // columns past the glyph pin to its last column, which is unlit for C
          cell_x_d = (unit_dx > x_coord_t'(GLYPH_W - 1)) ?
                     cell_x_t'(GLYPH_W - 1) : cell_x_t'(unit_dx);
          cell_y_d = cell_y_t'(i_y - UNIT_CELL_Y_LO);
        end
      end
      // off mode, nothing drawn
      default: region_d = RG_NONE;
    endcase
  end

  // first pipeline stage, region on tick n
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_region <= RG_NONE;
    end else if (i_pix_tick) begin
      o_region <= region_d;
    end
  end

  // offsets only matter with a glyph region
  always_ff @(posedge i_clk) begin
    if (i_pix_tick) begin
      o_cell_x <= cell_x_d;
      o_cell_y <= cell_y_d;
    end
  end

endmodule

/* verilog/screen_mode_fsm.sv */
`timescale 1ns/1ps

module screen_mode_fsm
  import video_geom_pkg::*, overlay_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst_n,
  input  logic         i_pix_tick,
  input  x_coord_t     i_x,
  input  y_coord_t     i_y,
  input  screen_mode_t i_mode,
  input  logic         i_fire,
  input  logic         i_warn,
  input  digit_t       i_tens,
  input  digit_t       i_ones,
  output screen_mode_t o_mode,
  output logic         o_fire,
  output logic         o_warn,
  output digit_t       o_tens,
  output digit_t       o_ones
);

  screen_mode_t state_q;
  screen_mode_t state_d;
  logic         frame_start;

  // frame start is the strobe at the top-left pixel
  assign frame_start = i_pix_tick && (i_x == FRAME_X0) && (i_y == FRAME_Y0);

  // jump straight to the requested mode
  // illegal codes keep the current one
  always_comb begin
    state_d = state_q;
    if (frame_start) begin
      case (i_mode)
        MODE_OFF, MODE_MENU, MODE_WORK: state_d = i_mode;
        default:                        state_d = state_q;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q <= MODE_OFF;
      o_fire  <= 1'b0;
      o_warn  <= 1'b0;
      o_tens  <= '0;
      o_ones  <= '0;
    end else begin
      state_q <= state_d;
      // status sampled together with the mode
      // so a whole frame sees one snapshot
      if (frame_start) begin
        o_fire <= i_fire;
        o_warn <= i_warn;
        o_tens <= i_tens;
        o_ones <= i_ones;
      end
    end
  end

  assign o_mode = state_q;

  a_state_onehot: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) $onehot(state_q)
  ) else $error("screen mode lost one-hot encoding");

endmodule

/* verilog/seg_glyph.sv */
`timescale 1ns/1ps

module seg_glyph
  import video_geom_pkg::*, overlay_pkg::*;
(
  input  glyph_code_t i_code,
  input  cell_x_t     i_cell_x,
  input  cell_y_t     i_cell_y,
  output logic        o_lit
);

  // segment enables, bit order a b c d e f g
  logic [6:0] seg_on;
  // position hits, same order
  logic [6:0] seg_hit;
  logic       in_cell;

  always_comb begin
    case (i_code)
      4'd0:      seg_on = 7'b1111110;
      4'd1:      seg_on = 7'b0110000;
      4'd2:      seg_on = 7'b1101101;
      4'd3:      seg_on = 7'b1111001;
      4'd4:      seg_on = 7'b0110011;
      4'd5:      seg_on = 7'b1011011;
      4'd6:      seg_on = 7'b1011111;
      4'd7:      seg_on = 7'b1110000;
      4'd8:      seg_on = 7'b1111111;
      4'd9:      seg_on = 7'b1111011;
      // C is the left half of an 8 minus the middle bar
      GL_UNIT_C: seg_on = 7'b1001110;
      default:   seg_on = 7'b0000000;
    endcase
  end

  assign in_cell = (i_cell_x < GLYPH_W) && (i_cell_y < GLYPH_H);

  // a top bar
  assign seg_hit[6] = (i_cell_x >= SEG_W) && (i_cell_x < GLYPH_W - SEG_W) &&
                      (i_cell_y < SEG_W);
  // b upper right
  assign seg_hit[5] = (i_cell_x >= GLYPH_W - SEG_W) && (i_cell_x < GLYPH_W) &&
                      (i_cell_y < GLYPH_H / 2);
  // c lower right
  assign seg_hit[4] = (i_cell_x >= GLYPH_W - SEG_W) && (i_cell_x < GLYPH_W) &&
                      (i_cell_y >= GLYPH_H / 2) && (i_cell_y < GLYPH_H);
  // d bottom bar
  assign seg_hit[3] = (i_cell_x >= SEG_W) && (i_cell_x < GLYPH_W - SEG_W) &&
                      (i_cell_y >= GLYPH_H - SEG_W) && (i_cell_y < GLYPH_H);
  // e lower left
  assign seg_hit[2] = (i_cell_x < SEG_W) &&
                      (i_cell_y >= GLYPH_H / 2) && (i_cell_y < GLYPH_H);
  // f upper left
  assign seg_hit[1] = (i_cell_x < SEG_W) && (i_cell_y < GLYPH_H / 2);
  // g middle bar, rows 55..64
  assign seg_hit[0] = (i_cell_x >= SEG_W) && (i_cell_x < GLYPH_W - SEG_W) &&
                      (i_cell_y >= GLYPH_H / 2 - SEG_W / 2) &&
                      (i_cell_y < GLYPH_H / 2 + SEG_W / 2);

  // full glyph ignores the segment map
  assign o_lit = (i_code == GL_FULL) ? in_cell : |(seg_on & seg_hit);

endmodule

/* verilog/status_overlay.sv */
`timescale 1ns/1ps

module status_overlay
  import video_geom_pkg::*, overlay_pkg::*;
#(
  parameter int PIX_DIV = 4
) (
  input  logic         i_clk,
  input  logic         i_rst_n,
  input  x_coord_t     i_x,
  input  y_coord_t     i_y,
  input  screen_mode_t i_mode,
  input  logic         i_fire,
  input  logic         i_warn,
  input  digit_t       i_tens,
  input  digit_t       i_ones,
  output logic [3:0]   o_red,
  output logic [3:0]   o_green,
  output logic [3:0]   o_blue
);

  logic         pix_tick;
  // per-frame snapshot of the status inputs
  screen_mode_t mode;
  logic         fire_q;
  logic         warn_q;
  digit_t       tens_q;
  digit_t       ones_q;
  // stage one results
  region_t      region;
  cell_x_t      cell_x;
  cell_y_t      cell_y;

  pixel_tick_gen #(
    .PIX_DIV (PIX_DIV)
  ) pixel_tick_gen_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .o_pix_tick (pix_tick)
  );

  screen_mode_fsm screen_mode_fsm_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_pix_tick (pix_tick),
    .i_x        (i_x),
    .i_y        (i_y),
    .i_mode     (i_mode),
    .i_fire     (i_fire),
    .i_warn     (i_warn),
    .i_tens     (i_tens),
    .i_ones     (i_ones),
    .o_mode     (mode),
    .o_fire     (fire_q),
    .o_warn     (warn_q),
    .o_tens     (tens_q),
    .o_ones     (ones_q)
  );

  region_decoder region_decoder_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_pix_tick (pix_tick),
    .i_x        (i_x),
    .i_y        (i_y),
    .i_mode     (mode),
    .i_fire     (fire_q),
    .i_warn     (warn_q),
    .o_region   (region),
    .o_cell_x   (cell_x),
    .o_cell_y   (cell_y)
  );

  pixel_shader pixel_shader_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_pix_tick (pix_tick),
    .i_region   (region),
    .i_cell_x   (cell_x),
    .i_cell_y   (cell_y),
    .i_tens     (tens_q),
    .i_ones     (ones_q),
    .o_red      (o_red),
    .o_green    (o_green),
    .o_blue     (o_blue)
  );

endmodule

/* verilog/video_geom_pkg.sv */
package video_geom_pkg;

  // display coordinates, 1-based like the scan source
  typedef logic [10:0] x_coord_t;
  typedef logic [9:0]  y_coord_t;

  // offsets inside one glyph cell
  typedef logic [6:0] cell_x_t;
  typedef logic [6:0] cell_y_t;

  // menu boxes, inclusive bounds
  localparam x_coord_t MENU_BOX0_X_LO = 11'd241, MENU_BOX0_X_HI = 11'd400;
  localparam y_coord_t MENU_BOX0_Y_LO = 10'd31,  MENU_BOX0_Y_HI = 10'd110;
  localparam x_coord_t MENU_BOX1_X_LO = 11'd191, MENU_BOX1_X_HI = 11'd450;
  localparam y_coord_t MENU_BOX1_Y_LO = 10'd141, MENU_BOX1_Y_HI = 10'd210;
  localparam x_coord_t MENU_BOX2_X_LO = 11'd191, MENU_BOX2_X_HI = 11'd450;
  localparam y_coord_t MENU_BOX2_Y_LO = 10'd241, MENU_BOX2_Y_HI = 10'd310;

  // alarm tiles along the top edge
  localparam x_coord_t FIRE_TILE_X_LO = 11'd521, FIRE_TILE_X_HI = 11'd640;
  localparam y_coord_t FIRE_TILE_Y_LO = 10'd1,   FIRE_TILE_Y_HI = 10'd120;
  localparam x_coord_t WARN_TILE_X_LO = 11'd401, WARN_TILE_X_HI = 11'd520;
  localparam y_coord_t WARN_TILE_Y_LO = 10'd1,   WARN_TILE_Y_HI = 10'd120;

  // temperature readout cells
  localparam x_coord_t TENS_CELL_X_LO = 11'd321, TENS_CELL_X_HI = 11'd400;
  localparam y_coord_t TENS_CELL_Y_LO = 10'd151, TENS_CELL_Y_HI = 10'd270;
  localparam x_coord_t ONES_CELL_X_LO = 11'd401, ONES_CELL_X_HI = 11'd480;
  localparam y_coord_t ONES_CELL_Y_LO = 10'd151, ONES_CELL_Y_HI = 10'd270;
  localparam x_coord_t UNIT_CELL_X_LO = 11'd501, UNIT_CELL_X_HI = 11'd620;
  localparam y_coord_t UNIT_CELL_Y_LO = 10'd151, UNIT_CELL_Y_HI = 10'd270;

  // first pixel of every frame
  localparam x_coord_t FRAME_X0 = 11'd1;
  localparam y_coord_t FRAME_Y0 = 10'd1;

  // seven-segment glyph geometry
  localparam int SEG_W   = 10;
  localparam int GLYPH_W = 80;
  localparam int GLYPH_H = 120;

endpackage
